// ==== rtl/busSizerPkg.sv ====
// Shared types for the bus sizer. The port data is 32 bits wide and a 16-bit port sits on the upper lanes

package busSizerPkg;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // 68040 SIZ encoding
    typedef enum logic [1:0] {
        byteSize = 2'b01,
        wordSize = 2'b10,
        lineSize = 2'b11,
        longSize = 2'b00
    } xferSizeT;

    // Sequencer states
    typedef enum logic [1:0] {
        idle        = 2'b00,
        firstCycle  = 2'b01,
        secondCycle = 2'b10,
        respond     = 2'b11
    } seqStateT;

    // Half-word routing between CPU lanes and port lanes
    typedef enum logic [1:0] {
        passThrough  = 2'b00,
        upperToLower = 2'b01,
        lowerToUpper = 2'b10
    } laneSelT;

    ////////////////////////////////////////////////////////////
    // Channel payloads
    ////////////////////////////////////////////////////////////

    // One CPU transfer request
    typedef struct packed {
        logic [1:0]  addrLow;
        xferSizeT    size;
        logic        readNotWrite;
        logic [31:0] writeData;
    } cpuReqT;

    // Answer back to the CPU
    typedef struct packed {
        logic [31:0] readData;
        logic        transferError;
        logic        burstInhibit;
    } cpuRespT;

    // One peripheral bus cycle, byteEnable[3] is the UU lane
    typedef struct packed {
        logic [1:0]  addrLow;
        logic        readNotWrite;
        logic [3:0]  byteEnable;
        logic [31:0] writeData;
    } portCycleT;

endpackage

// ==== rtl/busBufferControl.sv ====
// Transceiver and DMA control; bufferDir high means data flows toward the CPU side
`timescale 1ns/1ps

module busBufferControl (
    input  logic clk80,
    input  logic reset,
    input  logic localBusEnable,
    input  logic busGrant,
    input  logic portValid,
    input  logic readNotWrite,
    output logic bufferEnable,
    output logic bufferDir,
    output logic dmaActive
);

    logic dmaNext;

    // DMA takes the bus only between port cycles
    // Held until the grant comes back
    always_comb begin
        dmaNext = dmaActive;
        if (busGrant) begin
            dmaNext = 1'b0;
        end else if (!portValid) begin
            dmaNext = 1'b1;
        end
    end

    always_ff @(posedge clk80) begin
        if (reset) begin
            dmaActive    <= 1'b0;
            bufferEnable <= 1'b0;
            bufferDir    <= 1'b0;
        end else begin
            dmaActive    <= dmaNext;
            // Open during our own cycles, or for the DMA master
            bufferEnable <= (portValid & localBusEnable) | dmaNext;
            // CPU read or DMA write drives toward the CPU
            bufferDir    <= dmaNext ? ~readNotWrite : readNotWrite;
        end
    end

endmodule

// ==== rtl/sizingSequencer.sv ====
// Cycle FSM; one request in flight, port width learned at the first acknowledge only
`timescale 1ns/1ps

module sizingSequencer #(
    parameter int dataWidth = 32
) (
    input  logic                   clk80,
    input  logic                   reset,
    input  busSizerPkg::cpuReqT    cpuReq,
    input  logic                   cpuReqValid,
    input  logic                   cpuRespReady,
    input  logic                   portAck,
    input  logic                   portError,
    input  logic                   portIsWide,
    input  logic                   dmaActive,
    input  logic [dataWidth-1:0]   mergedReadData,
    output logic                   cpuReqReady,
    output logic                   cpuRespValid,
    output busSizerPkg::cpuRespT   cpuResp,
    output logic                   portValid,
    output busSizerPkg::portCycleT portCycle,
    output busSizerPkg::laneSelT   laneSel,
    output logic                   captureUpper,
    output logic                   captureLower
);

    busSizerPkg::seqStateT state;
    busSizerPkg::seqStateT stateNext;
    busSizerPkg::cpuReqT   reqReg;
    logic                  readyReg;
    logic                  errorReg;
    logic                  reqTaken;
    logic                  portAckOk;
    logic                  portFail;
    logic                  isSubword;
    logic                  upperShift;
    logic                  narrowShift;

    // 68040 lane order, address 0 on the UU lane
    function automatic logic [3:0] laneEnables(
        input busSizerPkg::xferSizeT size,
        input logic [1:0]            addrLow
    );
        logic [3:0] enables;
        case (size)
            busSizerPkg::byteSize: enables = 4'b1000 >> addrLow;
            busSizerPkg::wordSize: enables = addrLow[1] ? 4'b0011 : 4'b1100;
            default:               enables = 4'b1111;
        endcase
        return enables;
    endfunction

    ////////////////////////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////////////////////////

    // Ready tracks idle but stays low through reset
    assign cpuReqReady  = readyReg & ~dmaActive;
    assign reqTaken     = cpuReqValid & cpuReqReady;
    assign portValid    = (state == busSizerPkg::firstCycle) |
                          (state == busSizerPkg::secondCycle);
    assign cpuRespValid = (state == busSizerPkg::respond);

    // Error wins over a simultaneous acknowledge
    assign portFail  = portValid & portError;
    assign portAckOk = portValid & portAck & ~portError;

    assign isSubword = (reqReg.size == busSizerPkg::byteSize) |
                       (reqReg.size == busSizerPkg::wordSize);
    // Byte or word living in the lower half
    assign upperShift  = isSubword & reqReg.addrLow[1];
    // Narrow port returned it on the upper lanes
    assign narrowShift = upperShift & ~portIsWide;

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        stateNext = state;
        case (state)
            busSizerPkg::idle: begin
                if (reqTaken) begin
                    stateNext = busSizerPkg::firstCycle;
                end
            end
            busSizerPkg::firstCycle: begin
                if (portFail) begin
                    stateNext = busSizerPkg::respond;
                end else if (portAckOk) begin
                    // Narrow answer to a long needs the lower half too
                    stateNext = (isSubword | portIsWide) ? busSizerPkg::respond
                                                         : busSizerPkg::secondCycle;
                end
            end
            busSizerPkg::secondCycle: begin
                if (portFail | portAckOk) begin
                    stateNext = busSizerPkg::respond;
                end
            end
            default: begin
                // Held here while the CPU back-pressures
                if (cpuRespReady) begin
                    stateNext = busSizerPkg::idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk80) begin
        if (reset) begin
            state    <= busSizerPkg::idle;
            readyReg <= 1'b0;
            errorReg <= 1'b0;
        end else begin
            state    <= stateNext;
            readyReg <= (stateNext == busSizerPkg::idle);
            if (reqTaken) begin
                errorReg <= 1'b0;
            end else if (portFail) begin
                errorReg <= 1'b1;
            end
        end
    end

    // Request latch
    always_ff @(posedge clk80) begin
        if (reqTaken) begin
            reqReg <= cpuReq;
        end
    end

    ////////////////////////////////////////////////////////////
    // Port cycle and lane control
    ////////////////////////////////////////////////////////////

    always_comb begin
        portCycle.readNotWrite = reqReg.readNotWrite;
        portCycle.writeData    = reqReg.writeData;
        if (state == busSizerPkg::secondCycle) begin
            // Lower word of a long on a 16-bit port
            portCycle.addrLow    = 2'b10;
            portCycle.byteEnable = 4'b0011;
        end else begin
            portCycle.addrLow    = isSubword ? reqReg.addrLow : 2'b00;
            portCycle.byteEnable = laneEnables(reqReg.size, reqReg.addrLow);
        end
    end

    always_comb begin
        laneSel = busSizerPkg::passThrough;
        if (state == busSizerPkg::secondCycle) begin
            laneSel = reqReg.readNotWrite ? busSizerPkg::upperToLower
                                          : busSizerPkg::lowerToUpper;
        end else if (state == busSizerPkg::firstCycle && upperShift) begin
            if (!reqReg.readNotWrite) begin
                laneSel = busSizerPkg::lowerToUpper;
            end else if (narrowShift) begin
                laneSel = busSizerPkg::upperToLower;
            end
        end
    end

    // Read captures on the acknowledging edge only
    assign captureUpper = portAckOk & reqReg.readNotWrite &
                          (state == busSizerPkg::firstCycle) & ~narrowShift;
    assign captureLower = portAckOk & reqReg.readNotWrite;

    // Response, data zeroed on error and on writes
    always_comb begin
        cpuResp.readData      = (errorReg | ~reqReg.readNotWrite) ? '0 : mergedReadData;
        cpuResp.transferError = errorReg;
        cpuResp.burstInhibit  = (reqReg.size == busSizerPkg::lineSize);
    end

endmodule

// ==== rtl/dataLaneSteering.sv ====
// Half-word lane routing and read merge; dataWidth must be even, only 32 is exercised
`timescale 1ns/1ps

module dataLaneSteering #(
    parameter int dataWidth = 32
) (
    input  logic                 clk80,
    input  logic                 reset,
    input  busSizerPkg::laneSelT laneSel,
    input  logic                 captureUpper,
    input  logic                 captureLower,
    input  logic [dataWidth-1:0] cpuWriteData,
    input  logic [dataWidth-1:0] portReadData,
    output logic [dataWidth-1:0] portWriteData,
    output logic [dataWidth-1:0] mergedReadData
);

    localparam int halfWidth = dataWidth / 2;

    logic [dataWidth-1:0] readRouted;

    // Same routing both ways
    // Moved half is copied so the other lanes still carry it
    function automatic logic [dataWidth-1:0] routeHalves(
        input busSizerPkg::laneSelT route,
        input logic [dataWidth-1:0] data
    );
        logic [dataWidth-1:0] routed;
        case (route)
            busSizerPkg::upperToLower: begin
                routed = {data[dataWidth-1:halfWidth], data[dataWidth-1:halfWidth]};
            end
            busSizerPkg::lowerToUpper: begin
                routed = {data[halfWidth-1:0], data[halfWidth-1:0]};
            end
            default: begin
                routed = data;
            end
        endcase
        return routed;
    endfunction

    ////////////////////////////////////////////////////////////
    // Write path, purely combinational
    ////////////////////////////////////////////////////////////

    assign portWriteData = routeHalves(laneSel, cpuWriteData);

    ////////////////////////////////////////////////////////////
    // Read merge
    ////////////////////////////////////////////////////////////

    assign readRouted = routeHalves(laneSel, portReadData);

    // Each strobe loads its own half, other half holds
    always_ff @(posedge clk80) begin
        if (reset) begin
            mergedReadData <= '0;
        end else begin
            if (captureUpper) begin
                mergedReadData[dataWidth-1:halfWidth] <= readRouted[dataWidth-1:halfWidth];
            end
            if (captureLower) begin
                mergedReadData[halfWidth-1:0] <= readRouted[halfWidth-1:0];
            end
        end
    end

endmodule

// ==== rtl/busSizerTop.sv ====
// Bus sizer top; single clock clk80, 16-bit ports answer on the upper lanes with portIsWide low
`timescale 1ns/1ps

module busSizerTop #(
    parameter int dataWidth = 32
) (
    input  logic                   clk80,
    input  logic                   reset,
    input  busSizerPkg::cpuReqT    cpuReq,
    input  logic                   cpuReqValid,
    output logic                   cpuReqReady,
    output busSizerPkg::cpuRespT   cpuResp,
    output logic                   cpuRespValid,
    input  logic                   cpuRespReady,
    output busSizerPkg::portCycleT portCycle,
    output logic                   portValid,
    input  logic                   portAck,
    input  logic                   portError,
    input  logic                   portIsWide,
    input  logic [dataWidth-1:0]   portReadData,
    input  logic                   localBusEnable,
    input  logic                   busGrant,
    output logic                   bufferEnable,
    output logic                   bufferDir,
    output logic                   dmaActive
);

    // Sequencer cycle before write lanes are steered
    busSizerPkg::portCycleT seqCycle;
    busSizerPkg::laneSelT   laneSel;
    logic                   captureUpper;
    logic                   captureLower;
    logic [dataWidth-1:0]   mergedReadData;
    logic [dataWidth-1:0]   portWriteData;

    ////////////////////////////////////////////////////////////
    // Cycle sequencing
    ////////////////////////////////////////////////////////////

    sizingSequencer #(
        .dataWidth (dataWidth)
    ) sequencer (
        .clk80          (clk80),
        .reset          (reset),
        .cpuReq         (cpuReq),
        .cpuReqValid    (cpuReqValid),
        .cpuRespReady   (cpuRespReady),
        .portAck        (portAck),
        .portError      (portError),
        .portIsWide     (portIsWide),
        .dmaActive      (dmaActive),
        .mergedReadData (mergedReadData),
        .cpuReqReady    (cpuReqReady),
        .cpuRespValid   (cpuRespValid),
        .cpuResp        (cpuResp),
        .portValid      (portValid),
        .portCycle      (seqCycle),
        .laneSel        (laneSel),
        .captureUpper   (captureUpper),
        .captureLower   (captureLower)
    );

    // Data lanes
    dataLaneSteering #(
        .dataWidth (dataWidth)
    ) laneSteering (
        .clk80          (clk80),
        .reset          (reset),
        .laneSel        (laneSel),
        .captureUpper   (captureUpper),
        .captureLower   (captureLower),
        .cpuWriteData   (seqCycle.writeData),
        .portReadData   (portReadData),
        .portWriteData  (portWriteData),
        .mergedReadData (mergedReadData)
    );

    // Steered write lanes replace the raw ones
    assign portCycle = '{
        addrLow:      seqCycle.addrLow,
        readNotWrite: seqCycle.readNotWrite,
        byteEnable:   seqCycle.byteEnable,
        writeData:    portWriteData
    };

    ////////////////////////////////////////////////////////////
    // Transceivers and DMA
    ////////////////////////////////////////////////////////////

    busBufferControl bufferControl (
        .clk80          (clk80),
        .reset          (reset),
        .localBusEnable (localBusEnable),
        .busGrant       (busGrant),
        .portValid      (portValid),
        .readNotWrite   (seqCycle.readNotWrite),
        .bufferEnable   (bufferEnable),
        .bufferDir      (bufferDir),
        .dmaActive      (dmaActive)
    );

endmodule

// ==== bench/busSizerTb.sv ====
// Table-driven bench; 16-bit ports answer on the upper lanes, one request at a time, 200-cycle waits
`timescale 1ns/1ps

module busSizerTb;

    typedef struct packed {
        busSizerPkg::xferSizeT size;
        logic [1:0]            addrLow;
        logic                  readNotWrite;
        logic [31:0]           writeData;
        logic                  wide;
        logic [1:0]            errCycle;
        logic [2:0]            waitStates;
        logic                  randWait;
        logic [2:0]            holdResp;
    } entryT;

    localparam int numEntries = 16;
    localparam int waitLimit  = 200;

    logic                   clk80;
    logic                   reset;
    busSizerPkg::cpuReqT    cpuReq;
    logic                   cpuReqValid;
    logic                   cpuReqReady;
    busSizerPkg::cpuRespT   cpuResp;
    logic                   cpuRespValid;
    logic                   cpuRespReady;
    busSizerPkg::portCycleT portCycle;
    logic                   portValid;
    logic                   portAck;
    logic                   portError;
    logic                   portIsWide;
    logic [31:0]            portReadData;
    logic                   localBusEnable;
    logic                   busGrant;
    logic                   bufferEnable;
    logic                   bufferDir;
    logic                   dmaActive;

    entryT  stimTable [numEntries];
    integer seed = 32'h29e2_3040;
    int     errors = 0;
    int     checks = 0;
    logic   timedOut = 1'b0;

    busSizerTop #(.dataWidth(32)) i_dut (
        .clk80(clk80), .reset(reset), .cpuReq(cpuReq), .cpuReqValid(cpuReqValid),
        .cpuReqReady(cpuReqReady), .cpuResp(cpuResp), .cpuRespValid(cpuRespValid),
        .cpuRespReady(cpuRespReady), .portCycle(portCycle), .portValid(portValid),
        .portAck(portAck), .portError(portError), .portIsWide(portIsWide),
        .portReadData(portReadData), .localBusEnable(localBusEnable), .busGrant(busGrant),
        .bufferEnable(bufferEnable), .bufferDir(bufferDir), .dmaActive(dmaActive)
    );

    initial begin
        clk80 = 1'b0;
        forever #20 clk80 = ~clk80;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic noteTimeout(input string what);
        timedOut = 1'b1;
        errors++;
        $display("Timeout: %s", what);
    endtask

    // Port word per address, every address bit shows up
    function automatic logic [31:0] fillWord(input logic [1:0] addr);
        return 32'h5A3C_9617 ^ ({30'b0, addr} * 32'h1111_1111);
    endfunction

    function automatic logic [31:0] laneMask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic logic isSub(input entryT e);
        return (e.size == busSizerPkg::byteSize) || (e.size == busSizerPkg::wordSize);
    endfunction

    // Operand spans count bytes from an aligned start
    // Byte address k sits on lane 3-k
    function automatic logic [3:0] expEnables(input entryT e, input int cyc);
        int         first;
        int         count;
        logic [3:0] enables;
        if (e.size == busSizerPkg::byteSize) begin
            count = 1;
        end else if (e.size == busSizerPkg::wordSize) begin
            count = 2;
        end else begin
            count = 4;
        end
        first = int'(e.addrLow) & (4 - count);
        // Second narrow cycle carries bytes 2 and 3
        if (cyc == 1) begin
            first = 2;
            count = 2;
        end
        enables = 4'b0000;
        for (int k = 0; k < 4; k++) begin
            if (k >= first && k < first + count) begin
                enables[3 - k] = 1'b1;
            end
        end
        return enables;
    endfunction

    function automatic logic [1:0] expAddr(input entryT e, input int cyc);
        if (cyc == 1) return 2'b10;
        return isSub(e) ? e.addrLow : 2'b00;
    endfunction

    // Long and line split on a narrow port unless the first cycle fails
    function automatic int cycleCount(input entryT e);
        if (isSub(e) || e.wide || e.errCycle == 2'd1) return 1;
        return 2;
    endfunction

    ////////////////////////////////////////////////////////////
    // One table entry, with the port responder inline
    ////////////////////////////////////////////////////////////

    task automatic runEntry(input entryT e);
        int                   n;
        int                   t;
        int                   delay;
        logic                 shift;
        logic [3:0]           be;
        logic [31:0]          expData;
        logic [31:0]          expMask;
        logic [31:0]          firstWord;
        logic [31:0]          secondWord;
        busSizerPkg::cpuRespT held;
        n = cycleCount(e);
        cpuReq      = '{e.addrLow, e.size, e.readNotWrite, e.writeData};
        cpuReqValid = 1'b1;
        portIsWide  = e.wide;
        t = 0;
        while (!cpuReqReady && t < waitLimit) begin
            @(negedge clk80);
            t++;
        end
        if (!cpuReqReady) begin
            noteTimeout("request never accepted");
            return;
        end
        @(posedge clk80);
        @(negedge clk80);
        cpuReqValid = 1'b0;
        for (int c = 0; c < n; c++) begin
            t = 0;
            while (!portValid && t < waitLimit) begin
                @(negedge clk80);
                t++;
            end
            if (!portValid) begin
                noteTimeout("port cycle never started");
                return;
            end
            be    = expEnables(e, c);
            shift = (c == 1) || (isSub(e) && e.addrLow[1]);
            checkValue("portCycle.addrLow", 32'(portCycle.addrLow), 32'(expAddr(e, c)));
            checkValue("portCycle.byteEnable", 32'(portCycle.byteEnable), 32'(be));
            checkValue("portCycle.readNotWrite", 32'(portCycle.readNotWrite),
                       32'(e.readNotWrite));
            if (!e.readNotWrite) begin
                // Narrow port only sees the upper lanes
                if (e.wide) begin
                    expData = e.writeData;
                    expMask = laneMask(be);
                end else begin
                    expData = {shift ? e.writeData[15:0] : e.writeData[31:16], 16'h0};
                    expMask = {laneMask(shift ? {be[1:0], 2'b00} : be)};
                    expMask = {expMask[31:16], 16'h0};
                end
                checkValue("portCycle.writeData", portCycle.writeData & expMask, expData & expMask);
            end
            delay = e.randWait ? ($random(seed) & 3) : int'(e.waitStates);
            repeat (delay) begin
                @(negedge clk80);
                checkValue("portValid", 32'(portValid), 32'h1);
            end
            portReadData = fillWord(expAddr(e, c));
            if (int'(e.errCycle) == c + 1) begin
                portError = 1'b1;
            end else begin
                portAck = 1'b1;
            end
            @(negedge clk80);
            portAck   = 1'b0;
            portError = 1'b0;
            // Transceivers open and pointed toward the CPU for reads
            checkValue("bufferEnable", 32'(bufferEnable), 32'h1);
            checkValue("bufferDir", 32'(bufferDir), 32'(e.readNotWrite));
        end
        // Response one edge after the final acknowledge, no extra port cycle
        checkValue("cpuRespValid", 32'(cpuRespValid), 32'h1);
        checkValue("portValid", 32'(portValid), 32'h0);
        be = expEnables(e, 0);
        if (e.errCycle != 2'd0 || !e.readNotWrite) begin
            expData = 32'h0;
            expMask = 32'hFFFF_FFFF;
        end else if (e.wide) begin
            expData = fillWord(expAddr(e, 0));
            expMask = laneMask(be);
        end else if (isSub(e)) begin
            firstWord = fillWord(e.addrLow);
            expData   = e.addrLow[1] ? {16'h0, firstWord[31:16]} : firstWord;
            expMask   = laneMask(be);
        end else begin
            firstWord  = fillWord(2'b00);
            secondWord = fillWord(2'b10);
            expData    = {firstWord[31:16], secondWord[31:16]};
            expMask    = 32'hFFFF_FFFF;
        end
        checkValue("cpuResp.readData", cpuResp.readData & expMask, expData & expMask);
        checkValue("cpuResp.transferError", 32'(cpuResp.transferError), 32'(e.errCycle != 2'd0));
        checkValue("cpuResp.burstInhibit", 32'(cpuResp.burstInhibit),
                   32'(e.size == busSizerPkg::lineSize));
        // CPU back-pressure
        held = cpuResp;
        repeat (int'(e.holdResp)) begin
            @(negedge clk80);
            checkValue("cpuRespValid", 32'(cpuRespValid), 32'h1);
            checkValue("cpuResp.readData", cpuResp.readData, held.readData);
            checkValue("cpuResp.flags", 32'({cpuResp.transferError, cpuResp.burstInhibit}),
                       32'({held.transferError, held.burstInhibit}));
            checkValue("cpuReqReady", 32'(cpuReqReady), 32'h0);
        end
        cpuRespReady = 1'b1;
        @(negedge clk80);
        cpuRespReady = 1'b0;
        checkValue("cpuRespValid", 32'(cpuRespValid), 32'h0);
    endtask

    task automatic dmaCheck();
        int t;
        busGrant = 1'b0;
        t = 0;
        while (!dmaActive && t < waitLimit) begin
            @(negedge clk80);
            t++;
        end
        if (!dmaActive) begin
            noteTimeout("dmaActive never rose");
            return;
        end
        cpuReq      = '{2'b00, busSizerPkg::longSize, 1'b1, 32'h0};
        cpuReqValid = 1'b1;
        repeat (4) begin
            @(negedge clk80);
            checkValue("bufferEnable", 32'(bufferEnable), 32'h1);
            checkValue("cpuReqReady", 32'(cpuReqReady), 32'h0);
            checkValue("portValid", 32'(portValid), 32'h0);
        end
        cpuReqValid = 1'b0;
        busGrant    = 1'b1;
        t = 0;
        while (!cpuReqReady && t < waitLimit) begin
            @(negedge clk80);
            t++;
        end
        if (!cpuReqReady) begin
            noteTimeout("requests still blocked after grant returned");
            return;
        end
        checkValue("dmaActive", 32'(dmaActive), 32'h0);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        // size, addr, rnw, wdata, wide, err, wait, rand, hold
        stimTable[0]  = '{busSizerPkg::longSize, 2'd0, 1'b1, 32'h0,         1'b1, 2'd0, 3'd0, 1'b0, 3'd0};
        stimTable[1]  = '{busSizerPkg::longSize, 2'd0, 1'b0, 32'hDEAD_BEEF, 1'b1, 2'd0, 3'd1, 1'b0, 3'd0};
        stimTable[2]  = '{busSizerPkg::wordSize, 2'd2, 1'b1, 32'h0,         1'b1, 2'd0, 3'd0, 1'b0, 3'd0};
        stimTable[3]  = '{busSizerPkg::byteSize, 2'd1, 1'b0, 32'h1122_3344, 1'b1, 2'd0, 3'd0, 1'b0, 3'd0};
        stimTable[4]  = '{busSizerPkg::byteSize, 2'd3, 1'b1, 32'h0,         1'b1, 2'd0, 3'd2, 1'b0, 3'd0};
        stimTable[5]  = '{busSizerPkg::longSize, 2'd0, 1'b1, 32'h0,         1'b0, 2'd0, 3'd2, 1'b0, 3'd0};
        stimTable[6]  = '{busSizerPkg::longSize, 2'd0, 1'b0, 32'hCAFE_F00D, 1'b0, 2'd0, 3'd0, 1'b0, 3'd0};
        stimTable[7]  = '{busSizerPkg::byteSize, 2'd3, 1'b1, 32'h0,         1'b0, 2'd0, 3'd0, 1'b0, 3'd0};
        stimTable[8]  = '{busSizerPkg::wordSize, 2'd2, 1'b0, 32'h5566_7788, 1'b0, 2'd0, 3'd0, 1'b0, 3'd0};
        stimTable[9]  = '{busSizerPkg::wordSize, 2'd2, 1'b1, 32'h0,         1'b0, 2'd0, 3'd0, 1'b1, 3'd0};
        stimTable[10] = '{busSizerPkg::byteSize, 2'd1, 1'b1, 32'h0,         1'b0, 2'd0, 3'd0, 1'b1, 3'd0};
        stimTable[11] = '{busSizerPkg::longSize, 2'd0, 1'b1, 32'h0,         1'b1, 2'd1, 3'd0, 1'b0, 3'd0};
        stimTable[12] = '{busSizerPkg::longSize, 2'd0, 1'b1, 32'h0,         1'b0, 2'd2, 3'd1, 1'b0, 3'd0};
        stimTable[13] = '{busSizerPkg::longSize, 2'd0, 1'b0, 32'h0BAD_0BAD, 1'b0, 2'd1, 3'd0, 1'b0, 3'd0};
        stimTable[14] = '{busSizerPkg::lineSize, 2'd0, 1'b1, 32'h0,         1'b0, 2'd0, 3'd0, 1'b0, 3'd0};
        stimTable[15] = '{busSizerPkg::wordSize, 2'd0, 1'b1, 32'h0,         1'b0, 2'd0, 3'd0, 1'b0, 3'd3};
        reset          = 1'b1;
        cpuReq         = '0;
        cpuReqValid    = 1'b0;
        cpuRespReady   = 1'b0;
        portAck        = 1'b0;
        portError      = 1'b0;
        portIsWide     = 1'b1;
        portReadData   = 32'h0;
        localBusEnable = 1'b1;
        busGrant       = 1'b1;
        repeat (10) @(posedge clk80);
        @(negedge clk80);
        // Still inside reset here
        checkValue("cpuReqReady", 32'(cpuReqReady), 32'h0);
        checkValue("portValid", 32'(portValid), 32'h0);
        checkValue("cpuRespValid", 32'(cpuRespValid), 32'h0);
        checkValue("bufferEnable", 32'(bufferEnable), 32'h0);
        checkValue("dmaActive", 32'(dmaActive), 32'h0);
        reset = 1'b0;
        for (int i = 0; i < numEntries; i++) begin
            if (!timedOut) runEntry(stimTable[i]);
        end
        if (!timedOut) dmaCheck();
        // Traffic resumes after DMA
        if (!timedOut) runEntry(stimTable[14]);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timedOut) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/busSizerPkg.sv
rtl/busBufferControl.sv
rtl/sizingSequencer.sv
rtl/dataLaneSteering.sv
rtl/busSizerTop.sv
bench/busSizerTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build and run the bus sizer testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module busSizerTb -o busSizerSim \
    > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/busSizerSim > sim.log 2>&1 || { cat sim.log; echo "Simulation did not finish cleanly"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
